// ==== Bender.yml ====
package:
  name: ctrl_endp

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ctrl_endp_pkg.sv
      - rtl/setup_decoder.sv
      - rtl/device_state.sv
      - rtl/ctrl_stage_fsm.sv
      - rtl/in_data_source.sv
      - rtl/ctrl_endp.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_ctrl_endp.sv

// ==== all.f ====
+incdir+common
common/ctrl_endp_pkg.sv
rtl/setup_decoder.sv
rtl/device_state.sv
rtl/ctrl_stage_fsm.sv
rtl/in_data_source.sv
rtl/ctrl_endp.sv
test/tb_ctrl_endp.sv

// ==== common/ctrl_endp_defines.svh ====
// descriptor values and widths of the endpoint 0 control pipe, included by the package and rtl
`ifndef CTRL_ENDP_DEFINES_SVH
`define CTRL_ENDP_DEFINES_SVH

// idVendor and idProduct reported in the device descriptor
`define CE_VENDOR_ID 16'hfade
`define CE_PRODUCT_ID 16'h0c0d

// bMaxPacketSize0, full speed control pipe
`define CE_MAX_PACKET 8'd8

// standard device descriptor is the only table left
`define CE_DEV_DESCR_LEN 18

// byte counter width, large enough for the 18 byte descriptor
`define CE_BC_W 5

// usb device address
`define CE_ADDR_W 7

`endif

// ==== common/ctrl_endp_pkg.sv ====
// shared types of the endpoint 0 control pipe, imported by each rtl block and the testbench
`include "ctrl_endp_defines.svh"

package ctrl_endp_pkg;

   typedef enum logic [1:0] {
      DEV_POWERED    = 2'd0,
      DEV_DEFAULT    = 2'd1,
      DEV_ADDRESS    = 2'd2,
      DEV_CONFIGURED = 2'd3
   } dev_state_e;

   // control transfer stages
   typedef enum logic [1:0] {
      STG_IDLE  = 2'd0,
      STG_STALL = 2'd1,
      STG_SETUP = 2'd2,
      STG_DATA  = 2'd3
   } stage_e;

   typedef enum logic [2:0] {
      REQ_NONE              = 3'd0,
      REQ_GET_STATUS        = 3'd1,
      REQ_SET_ADDRESS       = 3'd2,
      REQ_GET_DESC_DEVICE   = 3'd3,
      REQ_GET_CONFIGURATION = 3'd4,
      REQ_SET_CONFIGURATION = 3'd5,
      REQ_UNSUPPORTED       = 3'd6
   } req_e;

   // bRequest codes, usb 2.0 table 9-4
   typedef enum logic [7:0] {
      STD_GET_STATUS        = 8'd0,
      STD_SET_ADDRESS       = 8'd5,
      STD_GET_DESCRIPTOR    = 8'd6,
      STD_GET_CONFIGURATION = 8'd8,
      STD_SET_CONFIGURATION = 8'd9
   } std_req_e;

   typedef struct packed {
      logic       setup;       // last checked pid was SETUP
      logic       in_data_ack; // ack received, with out_ready
      logic       out_valid;
      logic       out_err;
      logic       out_ready;   // one cycle strobe
      logic [7:0] out_data;
   } sie_rx_t;

   typedef struct packed {
      logic [7:0] data;
      logic       zlp;
      logic       valid;
   } in_tx_t;

   typedef struct packed {
      req_e                  req;
      logic                  in_dir;     // bmRequestType bit 7
      logic [`CE_ADDR_W-1:0] new_addr;
      logic                  configured; // SET_CONFIGURATION value 1
      logic [`CE_BC_W-1:0]   length;     // wLength, clamped
   } setup_req_t;

endpackage

// ==== rtl/ctrl_endp.sv ====
// endpoint 0 control pipe top level, connects the SIE strobes to the four control blocks
`include "ctrl_endp_defines.svh"

module ctrl_endp (
   input  logic                   clk_i,
   input  logic                   rstn_i,
   input  logic                   usb_reset_i,
   input  ctrl_endp_pkg::sie_rx_t rx_i,
   input  logic                   in_req_i,
   input  logic                   in_ready_i,
   output ctrl_endp_pkg::in_tx_t  tx_o,
   output logic [`CE_ADDR_W-1:0]  addr_o,
   output logic                   stall_o,
   output logic                   configured_o,
   output logic                   usb_en_o
);
   import ctrl_endp_pkg::*;

   setup_req_t          req;
   logic                setup_done;
   dev_state_e          dev_state;
   logic                commit;
   logic [`CE_BC_W-1:0] index;
   logic [7:0]          data;
   logic [`CE_BC_W-1:0] data_len;

   setup_decoder i_setup_decoder (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i & ~usb_reset_i), // bus reset drops a half parsed setup
      .rx_i         (rx_i),
      .dev_state_i  (dev_state),
      .req_o        (req),
      .setup_done_o (setup_done)
   );

   device_state i_device_state (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .rx_i         (rx_i),
      .usb_reset_i  (usb_reset_i),
      .commit_i     (commit),
      .req_i        (req),
      .dev_state_o  (dev_state),
      .addr_o       (addr_o),
      .usb_en_o     (usb_en_o),
      .configured_o (configured_o)
   );

   ctrl_stage_fsm i_ctrl_stage_fsm (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .rx_i         (rx_i),
      .usb_reset_i  (usb_reset_i),
      .in_req_i     (in_req_i),
      .in_ready_i   (in_ready_i),
      .req_i        (req),
      .setup_done_i (setup_done),
      .data_i       (data),
      .data_len_i   (data_len),
      .tx_o         (tx_o),
      .index_o      (index),
      .commit_o     (commit),
      .stall_o      (stall_o)
   );

   in_data_source i_in_data_source (
      .req_i       (req),
      .dev_state_i (dev_state),
      .index_i     (index),
      .data_o      (data),
      .data_len_o  (data_len)
   );

endmodule

// ==== rtl/ctrl_stage_fsm.sv ====
// control transfer stage sequencer, drives stall, the IN reply strobes and the data byte index
`include "ctrl_endp_defines.svh"

module ctrl_stage_fsm (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  ctrl_endp_pkg::sie_rx_t    rx_i,
   input  logic                      usb_reset_i,
   input  logic                      in_req_i,
   input  logic                      in_ready_i,
   input  ctrl_endp_pkg::setup_req_t req_i,
   input  logic                      setup_done_i,
   input  logic [7:0]                data_i,
   input  logic [`CE_BC_W-1:0]       data_len_i,
   output ctrl_endp_pkg::in_tx_t     tx_o,
   output logic [`CE_BC_W-1:0]       index_o,
   output logic                      commit_o,
   output logic                      stall_o
);
   import ctrl_endp_pkg::*;

   stage_e              stage_q, stage_d;
   logic [`CE_BC_W-1:0] cnt_q, cnt_d;
   logic                in_req_q;
   logic                rstn;      // por or bus reset
   logic                strobe;
   logic                ack;
   logic                last_byte;
   logic                tx_valid;
   logic                tx_zlp;

   assign rstn      = rstn_i & ~usb_reset_i;
   assign strobe    = rx_i.out_ready | in_ready_i;
   assign ack       = rx_i.out_ready & rx_i.in_data_ack;
   assign last_byte = (cnt_q == req_i.length) || (cnt_q == data_len_i);

   always_comb begin
      stage_d  = stage_q;
      cnt_d    = cnt_q;
      tx_valid = 1'b0;
      tx_zlp   = 1'b0;
      commit_o = 1'b0;
      if (rx_i.out_err) begin
         if (stage_q != STG_STALL)
            stage_d = STG_IDLE; // abort, a stalled pipe stays stalled
      end else if (rx_i.setup) begin
         stage_d = STG_SETUP;
         cnt_d   = '0;
      end else begin
         case (stage_q)
            STG_SETUP: begin
               if (!rx_i.out_valid) begin
                  if (!setup_done_i || req_i.req == REQ_UNSUPPORTED) begin
                     stage_d = STG_STALL;
                  end else if (req_i.in_dir) begin
                     stage_d = STG_DATA;
                  end else begin
                     // no-data request, status stage is a zlp
                     tx_valid = 1'b1;
                     tx_zlp   = 1'b1;
                     if (ack) begin
                        stage_d  = STG_IDLE;
                        commit_o = 1'b1;
                     end
                  end
               end
            end
            STG_DATA: begin
               if (rx_i.out_valid) begin
                  stage_d = STG_STALL; // host sent OUT data on a read
               end else if (last_byte) begin
                  if (in_req_q)
                     stage_d = STG_STALL;
                  else if (rx_i.out_ready && !rx_i.in_data_ack)
                     stage_d = STG_IDLE; // OUT status done
               end else begin
                  tx_valid = 1'b1;
                  if (in_req_q)
                     cnt_d = cnt_q + 1'b1;
               end
            end
            default: ; // idle and stall wait for setup
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i)
         in_req_q <= 1'b0;
      else
         in_req_q <= in_req_i;
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         stage_q <= STG_IDLE;
         cnt_q   <= '0;
      end else if (strobe) begin
         stage_q <= stage_d;
         cnt_q   <= cnt_d;
      end
   end

   assign tx_o.data  = data_i;
   assign tx_o.valid = tx_valid & in_req_q;
   assign tx_o.zlp   = tx_zlp & in_req_q;
   assign index_o    = cnt_q;
   assign stall_o    = (stage_q == STG_STALL);

endmodule

// ==== rtl/device_state.sv ====
// usb device state and address register, updated by bus reset and by committed requests
`include "ctrl_endp_defines.svh"

module device_state (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  ctrl_endp_pkg::sie_rx_t    rx_i,
   input  logic                      usb_reset_i,
   input  logic                      commit_i,
   input  ctrl_endp_pkg::setup_req_t req_i,
   output ctrl_endp_pkg::dev_state_e dev_state_o,
   output logic [`CE_ADDR_W-1:0]     addr_o,
   output logic                      usb_en_o,
   output logic                      configured_o
);
   import ctrl_endp_pkg::*;

   dev_state_e            dev_state_q;
   logic [`CE_ADDR_W-1:0] addr_q;
   logic                  usb_reset_q; // bus reset seen, not yet applied

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         dev_state_q <= DEV_POWERED;
         addr_q      <= '0;
         usb_reset_q <= 1'b0;
      end else begin
         usb_reset_q <= usb_reset_q | usb_reset_i;
         if (rx_i.out_ready) begin
            if (usb_reset_q) begin
               usb_reset_q <= 1'b0;
               dev_state_q <= DEV_DEFAULT;
               addr_q      <= '0;
            end else if (commit_i) begin
               case (req_i.req)
                  REQ_SET_ADDRESS: begin
                     addr_q      <= req_i.new_addr;
                     dev_state_q <= (req_i.new_addr == '0) ? DEV_DEFAULT : DEV_ADDRESS;
                  end
                  REQ_SET_CONFIGURATION: begin
                     dev_state_q <= req_i.configured ? DEV_CONFIGURED : DEV_ADDRESS;
                  end
                  default: ;
               endcase
            end
         end
      end
   end

   assign dev_state_o  = dev_state_q;
   assign addr_o       = addr_q;
   assign configured_o = (dev_state_q == DEV_CONFIGURED);
   assign usb_en_o     = !(dev_state_q == DEV_POWERED && !usb_reset_q); // off until first reset

endmodule

// ==== rtl/in_data_source.sv ====
// reply bytes of the IN data stage, device descriptor table and status values
`include "ctrl_endp_defines.svh"

module in_data_source (
   input  ctrl_endp_pkg::setup_req_t req_i,
   input  ctrl_endp_pkg::dev_state_e dev_state_i,
   input  logic [`CE_BC_W-1:0]       index_i,
   output logic [7:0]                data_o,
   output logic [`CE_BC_W-1:0]       data_len_o
);
   import ctrl_endp_pkg::*;

   localparam logic [7:0] DEV_DESCR [0:`CE_DEV_DESCR_LEN-1] = '{
      8'(`CE_DEV_DESCR_LEN),    // bLength
      8'h01,                    // bDescriptorType, device
      8'h00, 8'h02,             // bcdUSB 2.00
      8'h02,                    // communications class
      8'h00, 8'h00,             // subclass and protocol at interface level
      `CE_MAX_PACKET,
      8'(`CE_VENDOR_ID),  8'(`CE_VENDOR_ID >> 8),
      8'(`CE_PRODUCT_ID), 8'(`CE_PRODUCT_ID >> 8),
      8'h00, 8'h01,             // bcdDevice 1.00
      8'h00, 8'h00, 8'h00,      // no strings
      8'h01                     // bNumConfigurations
   };

   always_comb begin
      data_o     = 8'd0;
      data_len_o = '0;
      case (req_i.req)
         REQ_GET_DESC_DEVICE: begin
            data_len_o = `CE_BC_W'(`CE_DEV_DESCR_LEN);
            if (index_i < `CE_BC_W'(`CE_DEV_DESCR_LEN))
               data_o = DEV_DESCR[index_i];
         end
         REQ_GET_CONFIGURATION: begin
            data_len_o = `CE_BC_W'(1);
            data_o     = {7'd0, dev_state_i == DEV_CONFIGURED};
         end
         REQ_GET_STATUS: data_len_o = `CE_BC_W'(2); // self power and wakeup both off
         default: ;
      endcase
   end

endmodule

// ==== rtl/setup_decoder.sv ====
// SETUP packet parser, counts the eight bytes and builds the checked request for the fsm
`include "ctrl_endp_defines.svh"

module setup_decoder (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  ctrl_endp_pkg::sie_rx_t    rx_i,
   input  ctrl_endp_pkg::dev_state_e dev_state_i,
   output ctrl_endp_pkg::setup_req_t req_o,
   output logic                      setup_done_o
);
   import ctrl_endp_pkg::*;

   logic [3:0] byte_cnt_q;
   setup_req_t req_q;
   logic       not_default;
   logic       data_nz;

   assign not_default  = (dev_state_i != DEV_DEFAULT);
   assign data_nz      = |rx_i.out_data;
   assign setup_done_o = (byte_cnt_q == 4'd8);
   assign req_o        = req_q;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         byte_cnt_q <= '0;
         req_q      <= '0;
      end else if (rx_i.out_ready) begin
         if (rx_i.setup) begin
            byte_cnt_q <= '0; // new setup transaction
         end else if (rx_i.out_valid && !rx_i.out_err && !setup_done_o) begin
            byte_cnt_q <= byte_cnt_q + 4'd1;
            case (byte_cnt_q)
               4'd0: begin // bmRequestType
                  req_q.in_dir <= rx_i.out_data[7];
                  // standard type, device recipient only
                  req_q.req <= (|rx_i.out_data[6:0]) ? REQ_UNSUPPORTED : REQ_NONE;
               end
               4'd1: begin // bRequest
                  req_q.req <= REQ_UNSUPPORTED;
                  if (req_q.req == REQ_NONE) begin
                     case (rx_i.out_data)
                        STD_GET_STATUS: begin
                           if (req_q.in_dir && not_default)
                              req_q.req <= REQ_GET_STATUS;
                        end
                        STD_SET_ADDRESS: begin
                           if (!req_q.in_dir)
                              req_q.req <= REQ_SET_ADDRESS;
                        end
                        STD_GET_DESCRIPTOR: begin
                           if (req_q.in_dir)
                              req_q.req <= REQ_GET_DESC_DEVICE; // type checked in byte 3
                        end
                        STD_GET_CONFIGURATION: begin
                           if (req_q.in_dir && not_default)
                              req_q.req <= REQ_GET_CONFIGURATION;
                        end
                        STD_SET_CONFIGURATION: begin
                           if (!req_q.in_dir && not_default)
                              req_q.req <= REQ_SET_CONFIGURATION;
                        end
                        default: ;
                     endcase
                  end
               end
               4'd2: begin // wValue low
                  req_q.new_addr   <= rx_i.out_data[`CE_ADDR_W-1:0];
                  req_q.configured <= rx_i.out_data[0];
                  case (req_q.req)
                     REQ_SET_ADDRESS: if (rx_i.out_data[7]) req_q.req <= REQ_UNSUPPORTED;
                     REQ_SET_CONFIGURATION: begin
                        if (|rx_i.out_data[7:1])
                           req_q.req <= REQ_UNSUPPORTED; // only values 0 and 1
                     end
                     default: if (data_nz) req_q.req <= REQ_UNSUPPORTED;
                  endcase
               end
               4'd3: begin // wValue high
                  if (req_q.req == REQ_GET_DESC_DEVICE) begin
                     if (rx_i.out_data != 8'd1)
                        req_q.req <= REQ_UNSUPPORTED;
                  end else if (data_nz) begin
                     req_q.req <= REQ_UNSUPPORTED;
                  end
               end
               4'd4, 4'd5: if (data_nz) req_q.req <= REQ_UNSUPPORTED; // wIndex zero
               4'd6: begin // wLength low
                  req_q.length <= rx_i.out_data[`CE_BC_W-1:0];
                  case (req_q.req)
                     REQ_GET_DESC_DEVICE: if (|rx_i.out_data[7:`CE_BC_W]) req_q.length <= '1;
                     REQ_GET_STATUS: if (rx_i.out_data != 8'd2) req_q.req <= REQ_UNSUPPORTED;
                     REQ_GET_CONFIGURATION: begin
                        if (rx_i.out_data != 8'd1)
                           req_q.req <= REQ_UNSUPPORTED;
                     end
                     default: if (data_nz) req_q.req <= REQ_UNSUPPORTED;
                  endcase
               end
               4'd7: begin // wLength high
                  if (data_nz) begin
                     if (req_q.req == REQ_GET_DESC_DEVICE)
                        req_q.length <= '1; // clamp large reads
                     else
                        req_q.req <= REQ_UNSUPPORTED;
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== test/tb_ctrl_endp.sv ====
// testbench for the endpoint 0 control pipe, runs standard requests over SIE strobes and checks replies
`include "ctrl_endp_defines.svh"

module tb_ctrl_endp;
   timeunit 1ns;
   timeprecision 100ps;

   import ctrl_endp_pkg::*;

   localparam int WAIT_LIMIT = 64;
   localparam int MAX_BYTES  = 40;
   localparam logic [15:0] VID = `CE_VENDOR_ID;
   localparam logic [15:0] PID = `CE_PRODUCT_ID;

   logic                  clk_i = 1'b0;
   logic                  rstn_i;
   logic                  usb_reset_i;
   sie_rx_t               rx;
   logic                  in_req_i;
   logic                  in_ready_i;
   in_tx_t                tx_o;
   logic [`CE_ADDR_W-1:0] addr_o;
   logic                  stall_o;
   logic                  configured_o;
   logic                  usb_en_o;

   logic [7:0] descr [`CE_DEV_DESCR_LEN];
   logic [7:0] got [$];   // bytes of the last IN data stage
   logic [7:0] exp_q [$];
   int         checks = 0;
   int         errors = 0;

   ctrl_endp i_ctrl_endp (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .usb_reset_i  (usb_reset_i),
      .rx_i         (rx),
      .in_req_i     (in_req_i),
      .in_ready_i   (in_ready_i),
      .tx_o         (tx_o),
      .addr_o       (addr_o),
      .stall_o      (stall_o),
      .configured_o (configured_o),
      .usb_en_o     (usb_en_o)
   );

   always #5 clk_i = ~clk_i;

   stall_release: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (rx.out_ready && rx.setup) |=> !stall_o)
      else begin
         errors++;
         $display("stall_o stayed high after a setup strobe");
      end

   addr_on_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !$stable(addr_o) |-> $past(rx.out_ready && rx.in_data_ack))
      else begin
         errors++;
         $display("addr_o changed without a status ack");
      end

   // reply only one cycle after in_req
   valid_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
      tx_o.valid |-> $past(in_req_i))
      else begin
         errors++;
         $display("tx valid without in_req_i in the previous cycle");
      end

   zlp_is_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
      tx_o.zlp |-> tx_o.valid)
      else begin
         errors++;
         $display("tx zlp raised without tx valid");
      end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("checks %0d errors %0d", checks, errors);
      $display("tests failed");
      $finish;
   endtask

   task automatic check_value(input string name, input int exp, input int act);
      checks++;
      value_check: assert (exp == act)
         else begin
            errors++;
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
         end
   endtask

   task automatic idle_gap();
      repeat ($urandom_range(2, 0)) @(negedge clk_i);
   endtask

   // one cycle out_ready with the given flags
   task automatic out_strobe(input logic setup, input logic valid, input logic ack,
                             input logic [7:0] data);
      idle_gap();
      @(negedge clk_i);
      rx.setup       = setup;
      rx.out_valid   = valid;
      rx.in_data_ack = ack;
      rx.out_data    = data;
      rx.out_ready   = 1'b1;
      @(negedge clk_i);
      rx = '0;
   endtask

   task automatic send_setup(input logic [7:0] req_type, input logic [7:0] request,
                             input logic [15:0] value, input logic [15:0] index,
                             input logic [15:0] length);
      logic [7:0] pkt [8];
      pkt = '{req_type, request, value[7:0], value[15:8], index[7:0], index[15:8],
              length[7:0], length[15:8]};
      out_strobe(1'b1, 1'b0, 1'b0, 8'h00);
      foreach (pkt[i])
         out_strobe(1'b0, 1'b1, 1'b0, pkt[i]);
      out_strobe(1'b0, 1'b0, 1'b0, 8'h00); // end of the SETUP transaction
   endtask

   task automatic wait_tx_valid(input string name);
      int tries;
      tries = 0;
      while (!tx_o.valid) begin
         if (tries == WAIT_LIMIT)
            abort_run({"timeout waiting for tx valid in ", name});
         @(negedge clk_i);
         tries++;
      end
   endtask

   task automatic read_in_data(input string name);
      int n;
      n = 0;
      got.delete();
      @(negedge clk_i);
      in_req_i = 1'b1;
      @(negedge clk_i);
      wait_tx_valid(name);
      while (tx_o.valid && n < MAX_BYTES) begin
         got.push_back(tx_o.data);
         in_ready_i = 1'b1;
         @(negedge clk_i);
         in_ready_i = 1'b0;
         n++;
      end
      in_req_i = 1'b0;
      out_strobe(1'b0, 1'b0, 1'b0, 8'h00); // host OUT zlp for status
   endtask

   // device zlp for status, then host ack
   task automatic run_zlp_status(input string name, input int addr_before);
      @(negedge clk_i);
      in_req_i = 1'b1;
      @(negedge clk_i);
      wait_tx_valid(name);
      check_value({name, " zlp"}, 1, tx_o.zlp);
      in_ready_i = 1'b1;
      @(negedge clk_i);
      in_ready_i = 1'b0;
      in_req_i   = 1'b0;
      idle_gap();
      check_value({name, " addr before ack"}, addr_before, addr_o);
      out_strobe(1'b0, 1'b0, 1'b1, 8'h00);
   endtask

   task automatic compare_reply(input string name);
      check_value({name, " length"}, exp_q.size(), got.size());
      for (int i = 0; i < got.size() && i < exp_q.size(); i++)
         check_value($sformatf("%s byte %0d", name, i), exp_q[i], got[i]);
   endtask

   task automatic expect_descr(input int len);
      exp_q.delete();
      for (int i = 0; i < len; i++)
         exp_q.push_back(descr[i]);
   endtask

   // standard device descriptor, usb 2.0 table 9-8
   function automatic void build_descr();
      foreach (descr[i])
         descr[i] = 8'h00;
      descr[0]  = 8'(`CE_DEV_DESCR_LEN);
      descr[1]  = 8'h01;
      descr[3]  = 8'h02; // bcdUSB 2.00
      descr[4]  = 8'h02; // cdc device class
      descr[7]  = `CE_MAX_PACKET;
      descr[8]  = VID[7:0];
      descr[9]  = VID[15:8];
      descr[10] = PID[7:0];
      descr[11] = PID[15:8];
      descr[13] = 8'h01; // bcdDevice 1.00
      descr[17] = 8'h01; // one configuration
   endfunction

   initial begin
      void'($urandom(89));
      rstn_i      = 1'b0;
      usb_reset_i = 1'b0;
      rx          = '0;
      in_req_i    = 1'b0;
      in_ready_i  = 1'b0;
      build_descr();
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;

      check_value("reset usb_en", 0, usb_en_o);
      check_value("reset stall", 0, stall_o);
      check_value("reset configured", 0, configured_o);
      check_value("reset addr", 0, addr_o);
      check_value("reset tx valid", 0, tx_o.valid);
      check_value("reset tx zlp", 0, tx_o.zlp);
      usb_reset_i = 1'b1;
      repeat (3) @(negedge clk_i);
      usb_reset_i = 1'b0;
      out_strobe(1'b0, 1'b0, 1'b0, 8'h00);
      check_value("bus reset usb_en", 1, usb_en_o);

      send_setup(8'h80, 8'd6, 16'h0100, 16'h0000, 16'd64); // GET_DESCRIPTOR device
      read_in_data("get_descriptor 64");
      expect_descr(`CE_DEV_DESCR_LEN);
      compare_reply("get_descriptor 64");

      send_setup(8'h00, 8'd9, 16'd1, 16'h0000, 16'd0); // SET_CONFIGURATION in Default
      check_value("set_configuration default stall", 1, stall_o);
      send_setup(8'h80, 8'd6, 16'h0100, 16'h0000, 16'd8);
      check_value("stall after setup", 0, stall_o);
      read_in_data("get_descriptor 8");
      expect_descr(8);
      compare_reply("get_descriptor 8");

      send_setup(8'h00, 8'd5, 16'd5, 16'h0000, 16'd0);
      run_zlp_status("set_address", 0);
      check_value("set_address addr", 5, addr_o);

      send_setup(8'h00, 8'd9, 16'd1, 16'h0000, 16'd0);
      run_zlp_status("set_configuration", 5);
      check_value("set_configuration configured", 1, configured_o);
      send_setup(8'h80, 8'd8, 16'h0000, 16'h0000, 16'd1);
      read_in_data("get_configuration");
      exp_q = '{8'h01};
      compare_reply("get_configuration");
      send_setup(8'h80, 8'd0, 16'h0000, 16'h0000, 16'd2);
      read_in_data("get_status");
      exp_q = '{8'h00, 8'h00};
      compare_reply("get_status");

      send_setup(8'h00, 8'd3, 16'd1, 16'h0000, 16'd0); // SET_FEATURE is not handled
      check_value("unsupported request stall", 1, stall_o);
      send_setup(8'h80, 8'd8, 16'h0000, 16'h0000, 16'd1);
      check_value("stall after next setup", 0, stall_o);
      read_in_data("get_configuration after stall");
      exp_q = '{8'h01};
      compare_reply("get_configuration after stall");

      idle_gap();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
